//--- rtl/pps_pkg.sv
//--------------------------------------------------------------------------
// Shared definitions for the pps and heartbeat block
//   Counter widths and pulse timing
//   APB register offsets
//   XGMII idle, start and terminate words with their control bytes
//   Packed APB request/response and XGMII lane types
//--------------------------------------------------------------------------

`default_nettype none

package pps_pkg;

  // Pulse timing on the 10 MHz reference
  localparam int PPS_PERIOD_DEFAULT = 10_000_000;
  localparam int PPS_WIDTH          = 100;
  localparam int CTR_W              = 32;
  localparam int SEC_W              = 16;

  // APB register map
  localparam logic [7:0] REG_ADJUST = 8'h00;
  localparam logic [7:0] REG_STATUS = 8'h04;

  // XGMII lane encodings
  localparam logic [63:0] XGMII_IDLE_D     = 64'h0707_0707_0707_0707;
  localparam logic [63:0] XGMII_START_D    = 64'hd555_5555_5555_55fb;
  localparam logic [63:0] XGMII_TERM_D     = 64'h0707_0707_0707_07fd;
  localparam logic [7:0]  XGMII_CTRL_IDLE  = 8'hff;
  localparam logic [7:0]  XGMII_CTRL_START = 8'h01;
  localparam logic [7:0]  XGMII_CTRL_DATA  = 8'h00;

  // Heartbeat frame runs states 0 to BEAT_LAST
  localparam logic [3:0] BEAT_LAST = 4'd9;

  typedef struct packed {
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  ctrl;
  } xgmii_t;

endpackage

`default_nettype wire

//--- rtl/pps_apb_regs.sv
//--------------------------------------------------------------------------
// APB register block for the pps generator
//   REG_ADJUST holds the phase adjust value, each write toggles a request
//   REG_STATUS reports the count of generated seconds
//   Zero wait states, pslverr on unmapped offsets
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pps_apb_regs (
  input  logic                          TEN_MHZ_INA,
  input  logic                          arst_n,
  input  pps_pkg::apb_req_t             apb_req,
  output pps_pkg::apb_rsp_t             apb_rsp,
  input  logic [pps_pkg::SEC_W-1:0]     sec_count,
  output logic [pps_pkg::CTR_W-1:0]     adjust_value,
  output logic                          adjust_flag
);

  import pps_pkg::*;

  logic access;
  logic addr_hit;
  logic adjust_wr;

  // Access cycle of a transfer
  assign access    = apb_req.psel && apb_req.penable;
  assign addr_hit  = (apb_req.paddr == REG_ADJUST) || (apb_req.paddr == REG_STATUS);
  assign adjust_wr = access && apb_req.pwrite && (apb_req.paddr == REG_ADJUST);

  //--------------------------------------------------------------------------
  // Adjust register and request toggle
  //--------------------------------------------------------------------------
  always_ff @(posedge TEN_MHZ_INA or negedge arst_n) begin
    if (!arst_n) begin
      adjust_value <= '0;
      adjust_flag  <= 1'b0;
    end else if (adjust_wr) begin
      adjust_value <= apb_req.pwdata;
      // Generator picks up the request at its next wrap
      adjust_flag  <= ~adjust_flag;
    end
  end

  //--------------------------------------------------------------------------
  // Read path and response
  //--------------------------------------------------------------------------
  always_comb begin
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access && !addr_hit;
    apb_rsp.prdata  = '0;
    if (apb_req.psel && !apb_req.pwrite) begin
      case (apb_req.paddr)
        REG_ADJUST: apb_rsp.prdata = adjust_value;
        REG_STATUS: apb_rsp.prdata = {{(32 - SEC_W){1'b0}}, sec_count};
        default:    apb_rsp.prdata = '0;
      endcase
    end
  end

  // Access phase is only legal inside a selected transfer
  a_penable_needs_psel: assert property (
    @(posedge TEN_MHZ_INA) disable iff (!arst_n)
    apb_req.penable |-> apb_req.psel
  );

endmodule

`default_nettype wire

//--- rtl/pps_generator.sv
//--------------------------------------------------------------------------
// Internal pulse-per-second generator
//   Free-running second counter with phase adjust at the wrap
//   Registered pulse of PPS_WIDTH cycles and a seconds count
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pps_generator #(
  parameter int period = pps_pkg::PPS_PERIOD_DEFAULT
) (
  input  logic                          TEN_MHZ_INA,
  input  logic                          arst_n,
  input  logic [pps_pkg::CTR_W-1:0]     adjust_value,
  input  logic                          adjust_flag,
  output logic                          pps_out,
  output logic [pps_pkg::SEC_W-1:0]     sec_count
);

  import pps_pkg::*;

  logic [CTR_W-1:0] ctr;
  logic [CTR_W-1:0] ctr_next;
  logic             follow;
  logic             wrap;
  logic             take_adjust;

  assign wrap        = (ctr == CTR_W'(period - 1));
  // A pending request is seen as a mismatch between the two flags
  assign take_adjust = wrap && (follow != adjust_flag);

  always_comb begin
    if (!wrap) begin
      ctr_next = ctr + 1'b1;
    end else if (take_adjust) begin
      ctr_next = adjust_value;
    end else begin
      ctr_next = '0;
    end
  end

  always_ff @(posedge TEN_MHZ_INA or negedge arst_n) begin
    if (!arst_n) begin
      ctr       <= '0;
      follow    <= 1'b0;
      pps_out   <= 1'b0;
      sec_count <= '0;
    end else begin
      ctr     <= ctr_next;
      pps_out <= (ctr < CTR_W'(PPS_WIDTH));
      if (take_adjust) begin
        follow <= adjust_flag;
      end
      // Count each start of a second
      if (wrap && (ctr_next == '0)) begin
        sec_count <= sec_count + 1'b1;
      end
    end
  end

  // Software must keep the adjust value inside the period
  a_ctr_in_period: assert property (
    @(posedge TEN_MHZ_INA) disable iff (!arst_n)
    ctr < CTR_W'(period)
  );

  a_period_gt_width: assert property (
    @(posedge TEN_MHZ_INA) period > PPS_WIDTH
  );

endmodule

`default_nettype wire

//--- rtl/pps_beat_xgmii.sv
//--------------------------------------------------------------------------
// Heartbeat sender and receive-activity flag on one XGMII lane
//   Two-flop synchroniser for the external pps input
//   Ten-state frame machine driving the transmit lane
//   Registered send and receive activity flags
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pps_beat_xgmii (
  input  logic              TEN_MHZ_INA,
  input  logic              arst_n,
  input  logic              pps_in,
  input  pps_pkg::xgmii_t   xgmii_rx,
  output pps_pkg::xgmii_t   xgmii_tx,
  output logic              beat_send,
  output logic              beat_recv
);

  import pps_pkg::*;

  logic       pps_s1;
  logic       pps_s2;
  logic [3:0] beat_state;

  always_ff @(posedge TEN_MHZ_INA or negedge arst_n) begin
    if (!arst_n) begin
      pps_s1        <= 1'b0;
      pps_s2        <= 1'b0;
      beat_state    <= 4'd0;
      xgmii_tx.data <= XGMII_IDLE_D;
      xgmii_tx.ctrl <= XGMII_CTRL_IDLE;
      beat_send     <= 1'b0;
      beat_recv     <= 1'b0;
    end else begin
      pps_s1    <= pps_in;
      pps_s2    <= pps_s1;
      beat_send <= (beat_state != 4'd0);
      // Anything but all-idle control counts as activity
      beat_recv <= (xgmii_rx.ctrl != XGMII_CTRL_IDLE);

      //----------------------------------------------------------------------
      // Frame machine
      //----------------------------------------------------------------------
      case (beat_state)
        4'd0: begin
          xgmii_tx.data <= XGMII_IDLE_D;
          xgmii_tx.ctrl <= XGMII_CTRL_IDLE;
          if (pps_s2) begin
            beat_state <= 4'd1;
          end
        end
        4'd1: begin
          xgmii_tx.data <= XGMII_START_D;
          xgmii_tx.ctrl <= XGMII_CTRL_START;
          beat_state    <= 4'd2;
        end
        BEAT_LAST: begin
          xgmii_tx.data <= XGMII_TERM_D;
          xgmii_tx.ctrl <= XGMII_CTRL_IDLE;
          beat_state    <= 4'd0;
        end
        default: begin
          // Payload words carry the state number
          xgmii_tx.data <= 64'(beat_state);
          xgmii_tx.ctrl <= XGMII_CTRL_DATA;
          beat_state    <= beat_state + 4'd1;
        end
      endcase
    end
  end

  a_tx_ctrl_legal: assert property (
    @(posedge TEN_MHZ_INA) disable iff (!arst_n)
    (xgmii_tx.ctrl == XGMII_CTRL_IDLE) || (xgmii_tx.ctrl == XGMII_CTRL_START) ||
    (xgmii_tx.ctrl == XGMII_CTRL_DATA)
  );

endmodule

`default_nettype wire

//--- rtl/pps_beat_top.sv
//--------------------------------------------------------------------------
// Top level of the timing and heartbeat block
//   APB register block, pps generator and XGMII heartbeat side
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pps_beat_top #(
  parameter int period = pps_pkg::PPS_PERIOD_DEFAULT
) (
  input  logic                TEN_MHZ_INA,
  input  logic                arst_n,
  input  pps_pkg::apb_req_t   apb_req,
  output pps_pkg::apb_rsp_t   apb_rsp,
  input  logic                pps_in,
  output logic                pps_out,
  input  pps_pkg::xgmii_t     xgmii_rx,
  output pps_pkg::xgmii_t     xgmii_tx,
  output logic                beat_send,
  output logic                beat_recv
);

  import pps_pkg::*;

  logic [CTR_W-1:0] adjust_value;
  logic             adjust_flag;
  logic [SEC_W-1:0] sec_count;

  pps_apb_regs u_regs (
    .TEN_MHZ_INA  (TEN_MHZ_INA),
    .arst_n       (arst_n),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .sec_count    (sec_count),
    .adjust_value (adjust_value),
    .adjust_flag  (adjust_flag)
  );

  pps_generator #(
    .period (period)
  ) u_gen (
    .TEN_MHZ_INA  (TEN_MHZ_INA),
    .arst_n       (arst_n),
    .adjust_value (adjust_value),
    .adjust_flag  (adjust_flag),
    .pps_out      (pps_out),
    .sec_count    (sec_count)
  );

  // Heartbeat side runs from the external pulse only
  pps_beat_xgmii u_beat (
    .TEN_MHZ_INA (TEN_MHZ_INA),
    .arst_n      (arst_n),
    .pps_in      (pps_in),
    .xgmii_rx    (xgmii_rx),
    .xgmii_tx    (xgmii_tx),
    .beat_send   (beat_send),
    .beat_recv   (beat_recv)
  );

endmodule

`default_nettype wire

//--- include/tb_pps_beat_ref.svh
//--------------------------------------------------------------------------
// Reference model functions for the pps and heartbeat testbench
//   Expected spacing between pps_out rising edges
//   Expected XGMII word and control byte per heartbeat state
//--------------------------------------------------------------------------

`ifndef TB_PPS_BEAT_REF_SVH
`define TB_PPS_BEAT_REF_SVH

// Spacing in cycles from the previous rising edge
function automatic int ref_pps_spacing(input int period, input bit adjusted, input int adjust);
  int spacing;
  spacing = period;
  // The adjusted second makes no pulse of its own
  if (adjusted) begin
    spacing = 2 * period - adjust;
  end
  return spacing;
endfunction

function automatic pps_pkg::xgmii_t ref_beat_word(input int state);
  pps_pkg::xgmii_t word;
  word.data = pps_pkg::XGMII_IDLE_D;
  word.ctrl = pps_pkg::XGMII_CTRL_IDLE;
  if (state == 1) begin
    word.data = pps_pkg::XGMII_START_D;
    word.ctrl = pps_pkg::XGMII_CTRL_START;
  end else if (state == int'(pps_pkg::BEAT_LAST)) begin
    word.data = pps_pkg::XGMII_TERM_D;
    word.ctrl = pps_pkg::XGMII_CTRL_IDLE;
  end else if (state > 1 && state < int'(pps_pkg::BEAT_LAST)) begin
    word.data = 64'(state);
    word.ctrl = pps_pkg::XGMII_CTRL_DATA;
  end
  return word;
endfunction

`endif

//--- test/tb_pps_beat.sv
//--------------------------------------------------------------------------
// Testbench for the pps and heartbeat top level
//   Clock, reset, APB read and write tasks, LFSR for adjust values
//   Checking process for pps_out spacing and pulse width
//   Heartbeat frame, receive flag and register map tests
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_pps_beat;

  import pps_pkg::*;

  `include "tb_pps_beat_ref.svh"

  localparam int         PERIOD       = 400;
  localparam int         EDGE_TIMEOUT = 2 * PERIOD + 50;
  localparam logic [7:0] REG_UNUSED   = 8'h08;

  logic        TEN_MHZ_INA;
  logic        arst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        pps_in;
  logic        pps_out;
  xgmii_t      xgmii_rx;
  xgmii_t      xgmii_tx;
  logic        beat_send;
  logic        beat_recv;

  // State shared between the test sequence and the pps checker
  int          cycle;
  int          edges_seen;
  int          last_rise;
  bit          adj_pending;
  int          adj_value;
  logic        pps_prev;
  logic [31:0] lfsr_state;

  pps_beat_top #(
    .period (PERIOD)
  ) uut (
    .TEN_MHZ_INA (TEN_MHZ_INA),
    .arst_n      (arst_n),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .pps_in      (pps_in),
    .pps_out     (pps_out),
    .xgmii_rx    (xgmii_rx),
    .xgmii_tx    (xgmii_tx),
    .beat_send   (beat_send),
    .beat_recv   (beat_recv)
  );

  always #2 TEN_MHZ_INA = ~TEN_MHZ_INA;

  //--------------------------------------------------------------------------
  // Checks, timeouts and random values
  //--------------------------------------------------------------------------
  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("tests failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s did not happen", what);
    $display("tests failed");
    $fatal(1, "stopping on timeout");
  endtask

  // Galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  //--------------------------------------------------------------------------
  // APB transfers with a setup cycle then an access cycle
  //--------------------------------------------------------------------------
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic err);
    @(negedge TEN_MHZ_INA);
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    apb_req.pwrite  = 1'b1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge TEN_MHZ_INA);
    apb_req.penable = 1'b1;
    #1;
    check_equal("pready", apb_rsp.pready, 1);
    err = apb_rsp.pslverr;
    @(negedge TEN_MHZ_INA);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err);
    @(negedge TEN_MHZ_INA);
    apb_req.paddr   = addr;
    apb_req.pwrite  = 1'b0;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge TEN_MHZ_INA);
    apb_req.penable = 1'b1;
    #1;
    check_equal("pready", apb_rsp.pready, 1);
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    @(negedge TEN_MHZ_INA);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic wait_edges(input int target);
    int waited;
    int limit;
    waited = 0;
    limit  = EDGE_TIMEOUT * (target - edges_seen);
    while (edges_seen < target) begin
      @(posedge TEN_MHZ_INA);
      waited++;
      if (waited > limit) begin
        report_timeout("pps_out rising edge");
      end
    end
  endtask

  //--------------------------------------------------------------------------
  // pps_out checker for spacing against the reference and pulse width
  //--------------------------------------------------------------------------
  always @(negedge TEN_MHZ_INA) begin
    if (arst_n) begin
      cycle = cycle + 1;
      if (pps_out && !pps_prev) begin
        if (edges_seen > 0) begin
          check_equal("pps_out spacing", cycle - last_rise,
                      ref_pps_spacing(PERIOD, adj_pending, adj_value));
          adj_pending = 1'b0;
        end
        last_rise  = cycle;
        edges_seen = edges_seen + 1;
      end
      if (!pps_out && pps_prev) begin
        check_equal("pps_out width", cycle - last_rise, PPS_WIDTH);
      end
      pps_prev = pps_out;
    end
  end

  //--------------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------------
  initial begin
    logic        err;
    logic [31:0] rdata;
    int          pick;
    int          waited;
    xgmii_t      exp_word;
    TEN_MHZ_INA   = 1'b0;
    arst_n        = 1'b0;
    apb_req       = '0;
    pps_in        = 1'b0;
    xgmii_rx.data = XGMII_IDLE_D;
    xgmii_rx.ctrl = XGMII_CTRL_IDLE;
    cycle         = 0;
    edges_seen    = 0;
    last_rise     = 0;
    adj_pending   = 1'b0;
    adj_value     = 0;
    pps_prev      = 1'b0;
    lfsr_state    = 32'hb5b5;
    repeat (5) @(negedge TEN_MHZ_INA);
    // Outputs while still in reset
    check_equal("pps_out", pps_out, 0);
    check_equal("beat_send", beat_send, 0);
    check_equal("beat_recv", beat_recv, 0);
    check_equal("xgmii_tx.data", xgmii_tx.data, XGMII_IDLE_D);
    check_equal("xgmii_tx.ctrl", xgmii_tx.ctrl, XGMII_CTRL_IDLE);
    arst_n = 1'b1;
    apb_read(REG_STATUS, rdata, err);
    check_equal("REG_STATUS", rdata, 0);
    check_equal("pslverr", err, 0);
    apb_read(REG_ADJUST, rdata, err);
    check_equal("REG_ADJUST", rdata, 0);

    // One heartbeat frame from a short pps_in pulse
    @(negedge TEN_MHZ_INA);
    pps_in = 1'b1;
    waited = 0;
    while (xgmii_tx.ctrl !== XGMII_CTRL_START) begin
      @(negedge TEN_MHZ_INA);
      waited++;
      if (waited == 3) begin
        pps_in = 1'b0;
      end
      if (waited > 20) begin
        report_timeout("heartbeat start word");
      end
    end
    for (int s = 1; s <= int'(BEAT_LAST); s++) begin
      exp_word = ref_beat_word(s);
      check_equal("xgmii_tx.data", xgmii_tx.data, exp_word.data);
      check_equal("xgmii_tx.ctrl", xgmii_tx.ctrl, exp_word.ctrl);
      check_equal("beat_send", beat_send, 1);
      @(negedge TEN_MHZ_INA);
    end
    // Idle afterwards with no second frame
    exp_word = ref_beat_word(0);
    repeat (12) begin
      check_equal("xgmii_tx.data", xgmii_tx.data, exp_word.data);
      check_equal("xgmii_tx.ctrl", xgmii_tx.ctrl, exp_word.ctrl);
      check_equal("beat_send", beat_send, 0);
      @(negedge TEN_MHZ_INA);
    end

    // Receive activity flag
    xgmii_rx.ctrl = XGMII_CTRL_START;
    check_equal("beat_recv", beat_recv, 0);
    @(negedge TEN_MHZ_INA);
    check_equal("beat_recv", beat_recv, 1);
    xgmii_rx.ctrl = XGMII_CTRL_IDLE;
    @(negedge TEN_MHZ_INA);
    check_equal("beat_recv", beat_recv, 0);

    // Free-running seconds
    wait_edges(4);
    apb_read(REG_STATUS, rdata, err);
    check_equal("REG_STATUS", rdata, edges_seen - 1);

    // Phase adjust with three random values
    repeat (3) begin
      wait_edges(edges_seen + 1);
      pick        = PPS_WIDTH + (take_bits(9) % (PERIOD - PPS_WIDTH));
      adj_value   = pick;
      adj_pending = 1'b1;
      apb_write(REG_ADJUST, pick, err);
      check_equal("pslverr", err, 0);
      apb_read(REG_ADJUST, rdata, err);
      check_equal("REG_ADJUST", rdata, pick);
      wait_edges(edges_seen + 2);
    end

    // Unmapped offset
    apb_read(REG_UNUSED, rdata, err);
    check_equal("pslverr", err, 1);
    check_equal("prdata unused", rdata, 0);
    apb_write(REG_UNUSED, 32'h1234_5678, err);
    check_equal("pslverr", err, 1);
    apb_read(REG_ADJUST, rdata, err);
    check_equal("REG_ADJUST", rdata, adj_value);
    wait_edges(edges_seen + 2);
    apb_read(REG_STATUS, rdata, err);
    check_equal("REG_STATUS", rdata, edges_seen - 1);

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- pps_beat_top.f
+incdir+include
rtl/pps_pkg.sv
rtl/pps_apb_regs.sv
rtl/pps_generator.sv
rtl/pps_beat_xgmii.sv
rtl/pps_beat_top.sv
test/tb_pps_beat.sv

//--- Makefile
# Verilator build for the pps and heartbeat testbench

TOP := tb_pps_beat
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f pps_beat_top.f -Mdir $(OBJ)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
